// ==== rtl/cache_consts.svh ====
/*
 * Data cache geometry constants
 * Block size, set count, address width, queue depth, bus credits
 */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Words per cache block
`define BLOCK_WORDS 4

// Sets per way
`define CACHE_SETS 2

// Byte address width
`define ADDR_W 32

// Entries in each request and response queue
`define Q_DEPTH 4
// Bus grants one request credit per queue slot
`define BUS_CREDITS `Q_DEPTH

`endif

// ==== rtl/cpuPortPkg.sv ====
/*
 * Processor-side data cache types
 * Word, index and tag types, request and response structs, controller states
 */
`include "cache_consts.svh"

package cpuPortPkg;

    typedef logic [31:0] cpuWord;
    typedef logic [$clog2(`BLOCK_WORDS)-1:0] wordIdx;
    typedef logic [$clog2(`CACHE_SETS)-1:0] setIdx;
    // Address bits above set index and word offset
    typedef logic [`ADDR_W-3-$clog2(`BLOCK_WORDS)-$clog2(`CACHE_SETS):0] cacheTag;

    // Load or byte-masked store from the processor
    typedef struct packed {
        logic               valid;
        logic               write;
        logic [`ADDR_W-1:0] addr;
        cpuWord             wdata;
        logic [3:0]         byteMask;
    } cpuReq;

    typedef struct packed {
        cpuWord rdata;
        logic   stall;
    } cpuRsp;

    typedef enum logic [2:0] {idle, writeBack, refillReq, refillWait, done} cacheState;

endpackage

// ==== rtl/busPortPkg.sv ====
/*
 * Word bus beat types
 * Request beat toward memory and in-order read response
 */
`include "cache_consts.svh"

package busPortPkg;

    // One word per beat, write beats carry data
    typedef struct packed {
        logic [`ADDR_W-1:0] addr;
        logic               write;
        logic [31:0]        wdata;
    } busReq;

    // Read data only
    // one response per read beat, in issue order
    typedef struct packed {
        logic [31:0] rdata;
    } busRsp;

endpackage

// ==== rtl/creditQueue.sv ====
/*
 * Circular FIFO for any payload type
 * Credit pulse back to the sender per drained entry
 */
`timescale 1ns/1ps

module creditQueue #(
    parameter type payloadT = logic [31:0],
    parameter int  depth    = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  payloadT din,
    input  logic    pop,
    output payloadT dout,
    output logic    notEmpty,
    output logic    creditOut
);
    localparam int PW = (depth > 1) ? $clog2(depth) : 1;
    localparam int CW = $clog2(depth + 1);

    payloadT       mem [depth];
    logic [PW-1:0] wrPtr, rdPtr;
    logic [CW-1:0] count;
    logic          doPush, doPop, full;

    assign full     = count == CW'(depth);
    assign notEmpty = count != '0;
    assign doPush   = push && !full;
    assign doPop    = pop && notEmpty;
    // Head entry, visible the cycle after its push
    assign dout     = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            creditOut <= 1'b0;
        end else begin
            creditOut <= doPop;
            count     <= count + CW'(doPush) - CW'(doPop);
            if (doPush) begin
                wrPtr <= (wrPtr == PW'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PW'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
        end
    end

    // Sender pushed without holding a credit
    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push into full queue, credit protocol violated");

endmodule

// ==== rtl/cacheWayMemory.sv ====
/*
 * Two-way tag, valid, dirty and data storage
 * Per-set LRU bit, byte-masked word writes, combinational reads
 */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cacheWayMemory (
    input  logic                clk,
    input  logic                rst,
    input  cpuPortPkg::setIdx   set,
    input  logic [1:0]          wayWe,
    input  cpuPortPkg::wordIdx  wordSel,
    input  cpuPortPkg::cpuWord  wordData,
    input  logic [3:0]          byteMask,
    input  cpuPortPkg::cacheTag tagIn,
    input  logic                setValid,
    input  logic                setDirty,
    input  logic                lruWe,
    input  logic                lruWay,
    output cpuPortPkg::cacheTag tag0,
    output cpuPortPkg::cacheTag tag1,
    output logic                valid0,
    output logic                valid1,
    output logic                dirty0,
    output logic                dirty1,
    output cpuPortPkg::cpuWord  word0,
    output cpuPortPkg::cpuWord  word1,
    output logic                lruOut
);
    import cpuPortPkg::*;

    // Storage arrays, indexed way first
    cacheTag tagMem [2][`CACHE_SETS];
    cpuWord  dataMem [2][`CACHE_SETS][`BLOCK_WORDS];
    logic [1:0][`CACHE_SETS-1:0] validMem;
    logic [1:0][`CACHE_SETS-1:0] dirtyMem;
    // Way to evict next
    logic [`CACHE_SETS-1:0] lruMem;

    // Tag and data, only the addressed word takes the masked bytes
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (wayWe[w]) begin
                tagMem[w][set] <= tagIn;
                for (int b = 0; b < 4; b++) begin
                    if (byteMask[b]) begin
                        dataMem[w][set][wordSel][8*b +: 8] <= wordData[8*b +: 8];
                    end
                end
            end
        end
    end

    // Status bits
    always_ff @(posedge clk) begin
        if (rst) begin
            validMem <= '0;
            dirtyMem <= '0;
            lruMem   <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (wayWe[w]) begin
                    validMem[w][set] <= setValid;
                    dirtyMem[w][set] <= setDirty;
                end
            end
            if (lruWe) begin
                lruMem[set] <= lruWay;
            end
        end
    end

    // Lookup in the request cycle
    assign tag0   = tagMem[0][set];
    assign tag1   = tagMem[1][set];
    assign valid0 = validMem[0][set];
    assign valid1 = validMem[1][set];
    assign dirty0 = dirtyMem[0][set];
    assign dirty1 = dirtyMem[1][set];
    assign word0  = dataMem[0][set][wordSel];
    assign word1  = dataMem[1][set][wordSel];
    assign lruOut = lruMem[set];

    // A refill or a store targets exactly one way
    assert property (@(posedge clk) disable iff (rst) !(wayWe[0] && wayWe[1]))
        else $error("both ways written in one cycle");

endmodule

// ==== rtl/cacheController.sv ====
/*
 * Data cache controller
 * Hit detection, miss FSM, write-back and refill beats, request credits
 */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cacheController (
    input  logic                clk,
    input  logic                rst,
    input  cpuPortPkg::cpuReq   cpuIn,
    input  cpuPortPkg::cacheTag tag0,
    input  cpuPortPkg::cacheTag tag1,
    input  logic                valid0,
    input  logic                valid1,
    input  logic                dirty0,
    input  logic                dirty1,
    input  cpuPortPkg::cpuWord  word0,
    input  cpuPortPkg::cpuWord  word1,
    input  logic                lruOut,
    input  busPortPkg::busRsp   qRspData,
    input  logic                qRspValid,
    input  logic                reqCredit,
    output cpuPortPkg::cpuRsp   cpuOut,
    output cpuPortPkg::setIdx   set,
    output logic [1:0]          wayWe,
    output cpuPortPkg::wordIdx  wordSel,
    output cpuPortPkg::cpuWord  wordData,
    output logic [3:0]          byteMask,
    output cpuPortPkg::cacheTag tagIn,
    output logic                setValid,
    output logic                setDirty,
    output logic                lruWe,
    output logic                lruWay,
    output logic                reqPush,
    output busPortPkg::busReq   reqData,
    output logic                rspPop
);
    import cpuPortPkg::*;

    localparam int WB = $clog2(`BLOCK_WORDS);
    localparam int SB = $clog2(`CACHE_SETS);
    localparam int TB = $bits(cacheTag);
    localparam int CW = $clog2(`BUS_CREDITS + 1);

    cacheState     state, nextState;
    cacheTag       reqTag, victimTag;
    setIdx         reqSet;
    wordIdx        reqWord, issueCnt, refillCnt;
    cpuWord        victimWord;
    logic          hit0, hit1, hit, lookup;
    logic          victimWay, victimDirty;
    logic          canIssue, lastIssue, lastRefill;
    logic [CW-1:0] reqCredits;

    // ----------------------------------------
    // Address split and lookup
    // ----------------------------------------
    assign reqTag  = cpuIn.addr[`ADDR_W-1 -: TB];
    assign reqSet  = cpuIn.addr[2+WB +: SB];
    assign reqWord = cpuIn.addr[2 +: WB];

    assign hit0   = valid0 && (tag0 == reqTag);
    assign hit1   = valid1 && (tag1 == reqTag);
    assign hit    = hit0 || hit1;
    // Done state sees the freshly installed block as a hit
    assign lookup = cpuIn.valid && (state == idle || state == done);

    assign victimDirty = lruOut ? dirty1 : dirty0;
    assign victimTag   = victimWay ? tag1 : tag0;
    assign victimWord  = victimWay ? word1 : word0;

    assign cpuOut.rdata = hit1 ? word1 : word0;
    // Stall from the miss cycle until the block is installed
    assign cpuOut.stall = (state == idle) ? (cpuIn.valid && !hit) : (state != done);

    // ----------------------------------------
    // Bus beats
    // ----------------------------------------
    assign canIssue   = reqCredits != '0;
    assign lastIssue  = issueCnt == wordIdx'(`BLOCK_WORDS - 1);
    assign lastRefill = refillCnt == wordIdx'(`BLOCK_WORDS - 1);

    assign reqPush = canIssue && (state == writeBack || state == refillReq);
    assign rspPop  = qRspValid && (state == refillReq || state == refillWait);

    // Write beats go to the victim's old address, read beats to the new one
    assign reqData.addr  = {(state == writeBack) ? victimTag : reqTag, reqSet, issueCnt, 2'b00};
    assign reqData.write = state == writeBack;
    assign reqData.wdata = victimWord;

    // ----------------------------------------
    // Way memory controls
    // ----------------------------------------
    assign set = reqSet;

    always_comb begin
        wayWe    = '0;
        wordSel  = reqWord;
        wordData = cpuIn.wdata;
        byteMask = cpuIn.byteMask;
        tagIn    = reqTag;
        setValid = 1'b1;
        setDirty = 1'b1;
        lruWe    = 1'b0;
        lruWay   = !hit1;
        case (state)
            writeBack: begin
                wordSel = issueCnt;
            end
            refillReq, refillWait: begin
                // Whole words from the bus, valid only once the last lands
                wordSel          = refillCnt;
                wordData         = qRspData.rdata;
                byteMask         = 4'hF;
                setValid         = lastRefill;
                setDirty         = 1'b0;
                wayWe[victimWay] = rspPop;
            end
            default: begin
                if (lookup && hit) begin
                    lruWe        = 1'b1;
                    wayWe[hit1]  = cpuIn.write;
                end
            end
        endcase
    end

    // ----------------------------------------
    // Miss FSM
    // ----------------------------------------
    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (cpuIn.valid && !hit) begin
                    nextState = victimDirty ? writeBack : refillReq;
                end
            end
            writeBack: begin
                if (reqPush && lastIssue) begin
                    nextState = refillReq;
                end
            end
            refillReq: begin
                if (reqPush && lastIssue) begin
                    nextState = refillWait;
                end
            end
            refillWait: begin
                if (rspPop && lastRefill) begin
                    nextState = done;
                end
            end
            default: nextState = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            issueCnt   <= '0;
            refillCnt  <= '0;
            victimWay  <= 1'b0;
            reqCredits <= CW'(`BUS_CREDITS);
        end else begin
            state      <= nextState;
            reqCredits <= reqCredits + CW'(reqCredit) - CW'(reqPush);
            // Victim follows the LRU bit until a miss leaves idle
            if (state == idle) begin
                victimWay <= lruOut;
            end
            if (reqPush) begin
                issueCnt <= lastIssue ? '0 : issueCnt + 1'b1;
            end
            if (rspPop) begin
                refillCnt <= lastRefill ? '0 : refillCnt + 1'b1;
            end
        end
    end

    // Counter stays within the bus grant, a wrap means a beat without credit
    assert property (@(posedge clk) disable iff (rst) reqCredits <= CW'(`BUS_CREDITS))
        else $error("request credit counter out of range");

    // Responses only answer refill read beats
    assert property (@(posedge clk) disable iff (rst) (state == idle) |-> !qRspValid)
        else $error("bus response arrived while controller idle");

endmodule

// ==== rtl/dataCache.sv ====
/*
 * Data cache top level
 * Controller, way memory, bus request and response queues
 */
`timescale 1ns/1ps
`include "cache_consts.svh"

module dataCache (
    input  logic              clk,
    input  logic              rst,
    input  cpuPortPkg::cpuReq cpuIn,
    input  busPortPkg::busRsp rspIn,
    input  logic              rspValid,
    input  logic              reqCredit,
    output cpuPortPkg::cpuRsp cpuOut,
    output busPortPkg::busReq reqOut,
    output logic              reqValid,
    output logic              rspCredit
);
    import cpuPortPkg::*;
    import busPortPkg::*;

    // Way memory interface
    setIdx      set;
    wordIdx     wordSel;
    cpuWord     wordData, word0, word1;
    cacheTag    tagIn, tag0, tag1;
    logic [1:0] wayWe;
    logic [3:0] byteMask;
    logic       setValid, setDirty, lruWe, lruWay, lruOut;
    logic       valid0, valid1, dirty0, dirty1;

    // Queue interface
    busReq reqData;
    busRsp qRspData;
    logic  reqPush, rspPop, qRspValid;

    // ----------------------------------------
    // Lookup and miss handling
    // ----------------------------------------
    cacheController ctrl (.*);

    cacheWayMemory ways (.*);

    // ----------------------------------------
    // Bus side queues
    // ----------------------------------------
    // Bus takes a beat every cycle one is presented
    creditQueue #(.payloadT(busReq), .depth(`Q_DEPTH)) reqQ (
        .clk, .rst,
        .push(reqPush), .din(reqData), .pop(reqValid),
        .dout(reqOut), .notEmpty(reqValid), .creditOut()
    );

    // Each drained word hands a credit back to the bus
    creditQueue #(.payloadT(busRsp), .depth(`Q_DEPTH)) rspQ (
        .clk, .rst,
        .push(rspValid), .din(rspIn), .pop(rspPop),
        .dout(qRspData), .notEmpty(qRspValid), .creditOut(rspCredit)
    );

endmodule

// ==== verification/tbClockGen.sv ====
/*
 * Testbench clock and reset source
 */
`timescale 1ns/1ps

module tbClockGen #(
    parameter int period      = 40,
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2);
            clk = ~clk;
        end
    end

    // Reset held for whole cycles, released just after an edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

// ==== verification/dataCacheTb.sv ====
/*
 * Data cache testbench
 * Credit-based bus memory model with LFSR timing, access table, checks, watchdog
 */
`timescale 1ns/1ps
`include "cache_consts.svh"

module dataCacheTb;
    import cpuPortPkg::*;
    import busPortPkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int NUM_ACCESSES   = 25;
    localparam int MEM_WORDS      = 64;
    // Response delay of 0 to 7 cycles
    localparam int MAX_DELAY_BITS = 3;

    // One processor access and its expected outcome
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [31:0] data;
        logic [3:0]  mask;
        logic        hit;
    } accessT;

    logic  clk, rst;
    cpuReq cpuIn;
    cpuRsp cpuOut;
    busReq reqOut;
    busRsp rspIn;
    logic  reqValid, rspValid, reqCredit, rspCredit;

    accessT      tbl [NUM_ACCESSES];
    logic [31:0] memModel [MEM_WORDS];
    logic [31:0] shadow [MEM_WORDS];
    logic [31:0] lfsrState = 32'h201c_3b93;

    // Bus side bookkeeping
    int          busCycle;
    int          reqGrant;
    int          owedCredits;
    int          rspCredits;
    logic [31:0] rspDataQ [$];
    int          rspDueQ [$];

    tbClockGen #(.period(CLK_PERIOD), .resetCycles(5)) clkGen (.clk, .rst);

    dataCache dut_i (
        .clk, .rst, .cpuIn, .rspIn, .rspValid, .reqCredit,
        .cpuOut, .reqOut, .reqValid, .rspCredit
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // Right-shift Galois form of x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // One step per bit taken
    task automatic drawBits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    // Reset contents built from every address bit
    function automatic logic [31:0] fillWord(int idx);
        logic [15:0] byteAddr;
        byteAddr = 16'(idx * 4);
        return 32'h5EED_0000 ^ {byteAddr, ~byteAddr};
    endfunction

    // Masked bytes replace the old ones
    function automatic logic [31:0] mergeBytes(logic [31:0] old, logic [31:0] data,
                                               logic [3:0] mask);
        logic [31:0] merged;
        merged = old;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "stopped on bus or timing error");
    endtask

    function automatic accessT makeAccess(logic [31:0] addr, logic write, logic [31:0] data,
                                          logic [3:0] mask, logic hit);
        accessT a;
        a.addr  = addr;
        a.write = write;
        a.data  = data;
        a.mask  = mask;
        a.hit   = hit;
        return a;
    endfunction

    // ----------------------------------------
    // Access table
    // ----------------------------------------
    // Set 0 holds blocks 0x000 0x020 0x040
    // Set 1 holds blocks 0x010 0x030 0x050 0x070 0x090
    task automatic loadTable();
        // Each row is address, write flag, data, byte mask and expected hit
        tbl[0]  = makeAccess(32'h000, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[1]  = makeAccess(32'h004, 1'b0, 32'h0, 4'h0, 1'b1);
        tbl[2]  = makeAccess(32'h018, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[3]  = makeAccess(32'h02C, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[4]  = makeAccess(32'h000, 1'b0, 32'h0, 4'h0, 1'b1);
        tbl[5]  = makeAccess(32'h004, 1'b1, 32'h1122_3344, 4'b0101, 1'b1);
        tbl[6]  = makeAccess(32'h004, 1'b0, 32'h0, 4'h0, 1'b1);
        tbl[7]  = makeAccess(32'h028, 1'b1, 32'h9E37_79B9, 4'b1111, 1'b1);
        tbl[8]  = makeAccess(32'h00C, 1'b0, 32'h0, 4'h0, 1'b1);
        // Dirty 0x020 is LRU and gets written back
        tbl[9]  = makeAccess(32'h040, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[10] = makeAccess(32'h008, 1'b0, 32'h0, 4'h0, 1'b1);
        tbl[11] = makeAccess(32'h028, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[12] = makeAccess(32'h004, 1'b0, 32'h0, 4'h0, 1'b1);
        tbl[13] = makeAccess(32'h010, 1'b1, 32'hA1B2_C3D4, 4'b1000, 1'b1);
        tbl[14] = makeAccess(32'h034, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[15] = makeAccess(32'h050, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[16] = makeAccess(32'h010, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[17] = makeAccess(32'h044, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[18] = makeAccess(32'h03C, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[19] = makeAccess(32'h020, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[20] = makeAccess(32'h054, 1'b0, 32'h0, 4'h0, 1'b0);
        // Store miss allocates the block before the merge
        tbl[21] = makeAccess(32'h074, 1'b1, 32'h0F1E_2D3C, 4'b0011, 1'b0);
        tbl[22] = makeAccess(32'h074, 1'b0, 32'h0, 4'h0, 1'b1);
        tbl[23] = makeAccess(32'h030, 1'b0, 32'h0, 4'h0, 1'b0);
        tbl[24] = makeAccess(32'h090, 1'b0, 32'h0, 4'h0, 1'b0);
    endtask

    // Drive one access and check hit timing and data
    task automatic runAccess(input int n, input accessT a);
        int idx;
        idx = int'(a.addr[31:2]);
        @(posedge clk);
        #2;
        cpuIn.valid    = 1'b1;
        cpuIn.write    = a.write;
        cpuIn.addr     = a.addr;
        cpuIn.wdata    = a.data;
        cpuIn.byteMask = a.mask;
        @(negedge clk);
        // A hit never stalls in the request cycle
        checkValue($sformatf("cpuOut.stall[%0d]", n), 32'(cpuOut.stall), 32'(!a.hit));
        while (cpuOut.stall !== 1'b0) begin
            @(negedge clk);
        end
        if (a.write) begin
            shadow[idx] = mergeBytes(shadow[idx], a.data, a.mask);
        end else begin
            checkValue($sformatf("cpuOut.rdata[%0d]", n), cpuOut.rdata, shadow[idx]);
        end
    endtask

    // ----------------------------------------
    // Bus and memory model
    // ----------------------------------------
    task automatic acceptBeat(input busReq beat);
        int idx;
        int delay;
        int due;
        idx = int'(beat.addr[31:2]);
        reqGrant--;
        owedCredits++;
        if (beat.write) begin
            memModel[idx] = beat.wdata;
        end else begin
            drawBits(MAX_DELAY_BITS, delay);
            due = busCycle + 1 + delay;
            // Responses stay in issue order
            if (rspDueQ.size() > 0 && due < rspDueQ[$]) begin
                due = rspDueQ[$];
            end
            rspDueQ.push_back(due);
            rspDataQ.push_back(memModel[idx]);
        end
    endtask

    initial begin
        int give;
        rspIn       = '0;
        rspValid    = 1'b0;
        reqCredit   = 1'b0;
        busCycle    = 0;
        owedCredits = 0;
        reqGrant    = `BUS_CREDITS;
        rspCredits  = `Q_DEPTH;
        forever begin
            @(posedge clk);
            #2;
            busCycle++;
            // Request credits come back at a random pace
            reqCredit = 1'b0;
            drawBits(1, give);
            if (owedCredits > 0 && give == 1) begin
                reqCredit = 1'b1;
                owedCredits--;
                reqGrant++;
            end
            // Oldest response goes out once due and only while a credit is held
            rspValid = 1'b0;
            if (rspDueQ.size() > 0 && rspDueQ[0] <= busCycle && rspCredits > 0) begin
                rspValid    = 1'b1;
                rspIn.rdata = rspDataQ.pop_front();
                rspDueQ.delete(0);
                rspCredits--;
            end
            // Beats and credits seen here take effect at the coming edge
            @(negedge clk);
            if (rspCredit === 1'b1) begin
                rspCredits++;
            end
            if (reqValid === 1'b1) begin
                if (reqGrant == 0) begin
                    stopRun("Bus received a request beat while holding no free credit");
                end else if (reqOut.addr >= 32'(MEM_WORDS * 4)) begin
                    stopRun("Bus request address lies outside the memory model");
                end else begin
                    acceptBeat(reqOut);
                end
            end
        end
    end

    // ----------------------------------------
    // Watchdog and main sequence
    // ----------------------------------------
    initial begin
        #(NUM_ACCESSES * 200 * CLK_PERIOD);
        stopRun("Timeout: the access table did not complete in time");
    end

    initial begin
        cpuIn = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            memModel[i] = fillWord(i);
            shadow[i]   = fillWord(i);
        end
        loadTable();
        @(negedge rst);
        @(negedge clk);
        // Nothing active out of reset
        checkValue("cpuOut.stall", 32'(cpuOut.stall), 32'h0);
        checkValue("reqValid", 32'(reqValid), 32'h0);
        checkValue("rspCredit", 32'(rspCredit), 32'h0);
        for (int i = 0; i < NUM_ACCESSES; i++) begin
            runAccess(i, tbl[i]);
        end
        @(posedge clk);
        #2;
        cpuIn = '0;
        // All dirty blocks went back to memory by now
        for (int i = 0; i < MEM_WORDS; i++) begin
            checkValue($sformatf("memory word 0x%0h", i * 4), memModel[i], shadow[i]);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/cpuPortPkg.sv
rtl/busPortPkg.sv
rtl/creditQueue.sv
rtl/cacheWayMemory.sv
rtl/cacheController.sv
rtl/dataCache.sv
verification/tbClockGen.sv
verification/dataCacheTb.sv

// ==== Bender.yml ====
package:
  name: dataCache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpuPortPkg.sv
      - rtl/busPortPkg.sv
      - rtl/creditQueue.sv
      - rtl/cacheWayMemory.sv
      - rtl/cacheController.sv
      - rtl/dataCache.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/tbClockGen.sv
      - verification/dataCacheTb.sv
